// File: src/cps_mem_pkg.sv
//////////////////////////////
// CPS memory package
// Memory map constants, access
// target enum and the request
// structs shared by the ports
//////////////////////////////

`default_nettype none

package cps_mem_pkg;

    // Word address width of one 32K-word memory
    localparam int RAM_AW = 15;

    // 68000 bus word
    localparam int RAM_DW = 16;

    // Video banks present on the board
    localparam int VRAM_BANKS = 3;

    // Absent bank reads and post-reset output value
    localparam logic [RAM_DW-1:0] IDLE_DATA = 16'hffff;

    // Where a CPU access lands
    typedef enum logic [2:0] {
        TGT_WRAM  = 3'd0,
        TGT_VRAM0 = 3'd1,
        TGT_VRAM1 = 3'd2,
        TGT_VRAM2 = 3'd3,
        TGT_NONE  = 3'd4
    } mem_target_e;

    // CPU-side memory port bundle, common to all four memories
    typedef struct packed {
        logic [RAM_AW-1:0] addr;
        logic [RAM_DW-1:0] data;
        // Bit 1 high byte, bit 0 low byte
        logic [1:0]        be;
    } mem_wr_t;

    // Request held by the first CPU stage
    typedef struct packed {
        mem_target_e target;
        mem_wr_t     wr;
        logic        rnw;
        // Set while the request waits for its return cycle
        logic        live;
    } cpu_req_t;

endpackage

`default_nettype wire

// File: src/cps_word_ram.sv
//////////////////////////////
// Work RAM
// 32K x 16 synchronous RAM
// with byte-lane writes
//////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module cps_word_ram (
    input  wire logic                         clk_cpu,
    input  wire cps_mem_pkg::mem_wr_t         wr,
    input  wire logic [1:0]                   we,
    output logic [cps_mem_pkg::RAM_DW-1:0]    q
);

    logic [cps_mem_pkg::RAM_DW-1:0] mem [2**cps_mem_pkg::RAM_AW];
    logic [1:0] lane_we;

    // Enable qualified by the strobes carried with the request
    assign lane_we = we & wr.be;

    always_ff @(posedge clk_cpu) begin
        if (lane_we[1]) begin
            mem[wr.addr][15:8] <= wr.data[15:8];
        end
        if (lane_we[0]) begin
            mem[wr.addr][7:0] <= wr.data[7:0];
        end
        // Read-first, old word on a write
        q <= mem[wr.addr];
    end

endmodule

`default_nettype wire

// File: src/cps_vram_bank.sv
//////////////////////////////
// Video RAM bank
// Dual-clock 32K x 16 RAM, byte
// writable CPU port and a
// read-only graphics port
//////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module cps_vram_bank (
    input  wire logic                         clk_cpu,
    input  wire logic                         clk_gfx,
    input  wire cps_mem_pkg::mem_wr_t         wr,
    input  wire logic [1:0]                   we,
    output logic [cps_mem_pkg::RAM_DW-1:0]    q,
    input  wire logic [cps_mem_pkg::RAM_AW-1:0] dma_addr,
    output logic [cps_mem_pkg::RAM_DW-1:0]    dma_q
);

    logic [cps_mem_pkg::RAM_DW-1:0] mem [2**cps_mem_pkg::RAM_AW];
    logic [1:0] lane_we;

    assign lane_we = we & wr.be;

    // Port A, CPU clock
    always_ff @(posedge clk_cpu) begin
        if (lane_we[1]) begin
            mem[wr.addr][15:8] <= wr.data[15:8];
        end
        if (lane_we[0]) begin
            mem[wr.addr][7:0] <= wr.data[7:0];
        end
        q <= mem[wr.addr];
    end

    // Port B, graphics clock, read only
    // Same-word collision with port A gives undefined data here
    always_ff @(posedge clk_gfx) begin
        dma_q <= mem[dma_addr];
    end

endmodule

`default_nettype wire

// File: src/cps_cpu_port.sv
//////////////////////////////
// CPU memory port
// Captures 68000 requests on the
// select edge and returns the
// read word with main_ram_ok
//////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module cps_cpu_port (
    input  wire logic                  clk_cpu,
    input  wire logic                  rst,
    input  wire logic                  main_ram_cs,
    input  wire logic                  main_vram_cs,
    input  wire logic                  main_rnw,
    input  wire logic [1:0]            dsn,
    input  wire logic [16:0]           main_ram_addr,
    input  wire logic [15:0]           main_dout,
    output logic                       main_ram_ok,
    output logic [15:0]                main_ram_data,
    output cps_mem_pkg::mem_wr_t       mem_wr,
    output logic [1:0]                 wram_we,
    output logic [cps_mem_pkg::VRAM_BANKS-1:0][1:0] vram_we,
    input  wire logic [15:0]           wram_q,
    input  wire logic [cps_mem_pkg::VRAM_BANKS-1:0][15:0] vram_q
);

    cps_mem_pkg::cpu_req_t    req;
    cps_mem_pkg::mem_target_e target;
    logic        cs_last;
    logic        start;
    logic [1:0]  be;
    logic [1:0]  stage;
    logic [15:0] ret_word;

    assign start = (main_ram_cs | main_vram_cs) & ~cs_last;

    // Byte strobes only matter on writes
    assign be = ~dsn & {2{~main_rnw}};

    always_comb begin
        if (main_ram_cs) begin
            target = cps_mem_pkg::TGT_WRAM;
        end else begin
            case (main_ram_addr[16:15])
                2'd0:    target = cps_mem_pkg::TGT_VRAM0;
                2'd1:    target = cps_mem_pkg::TGT_VRAM1;
                2'd2:    target = cps_mem_pkg::TGT_VRAM2;
                default: target = cps_mem_pkg::TGT_NONE;
            endcase
        end
    end

    // Word picked in the return cycle
    always_comb begin
        case (req.target)
            cps_mem_pkg::TGT_WRAM:  ret_word = wram_q;
            cps_mem_pkg::TGT_VRAM0: ret_word = vram_q[0];
            cps_mem_pkg::TGT_VRAM1: ret_word = vram_q[1];
            cps_mem_pkg::TGT_VRAM2: ret_word = vram_q[2];
            default:                ret_word = cps_mem_pkg::IDLE_DATA;
        endcase
    end

    always_ff @(posedge clk_cpu or posedge rst) begin
        if (rst) begin
            cs_last       <= 1'b0;
            req           <= '{target: cps_mem_pkg::TGT_NONE, default: '0};
            wram_we       <= '0;
            vram_we       <= '0;
            stage         <= '0;
            main_ram_ok   <= 1'b0;
            main_ram_data <= cps_mem_pkg::IDLE_DATA;
        end else begin
            cs_last <= main_ram_cs | main_vram_cs;
            stage   <= {stage[0], 1'b0};
            // Enables last one cycle only
            wram_we <= '0;
            vram_we <= '0;
            if (start) begin
                req.target  <= target;
                req.wr.addr <= main_ram_addr[14:0];
                req.wr.data <= main_dout;
                req.wr.be   <= be;
                req.rnw     <= main_rnw;
                req.live    <= 1'b1;
                stage       <= 2'b01;
                main_ram_ok <= 1'b0;
                if (target == cps_mem_pkg::TGT_WRAM) begin
                    wram_we <= be;
                end
                for (int b = 0; b < cps_mem_pkg::VRAM_BANKS; b++) begin
                    if (main_vram_cs && main_ram_addr[16:15] == b[1:0]) begin
                        vram_we[b] <= be;
                    end
                end
            end else if (stage[1] && req.live) begin
                req.live    <= 1'b0;
                main_ram_ok <= 1'b1;
                // Write data is left as it was
                if (req.rnw) begin
                    main_ram_data <= ret_word;
                end
            end
        end
    end

    assign mem_wr = req.wr;

    // The CPU decoder never selects both memories
    a_one_cs: assert property (@(posedge clk_cpu) disable iff (rst)
        !(main_ram_cs && main_vram_cs));

    // Only one memory is written per access
    a_one_we: assert property (@(posedge clk_cpu) disable iff (rst)
        $onehot0({|wram_we, |vram_we[2], |vram_we[1], |vram_we[0]}));

endmodule

`default_nettype wire

// File: src/cps_dma_port.sv
//////////////////////////////
// Graphics DMA port
// Level-select read pipeline
// into the three video banks
//////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module cps_dma_port (
    input  wire logic                  clk_gfx,
    input  wire logic                  rst,
    input  wire logic                  vram_dma_cs,
    input  wire logic [16:0]           vram_dma_addr,
    output logic [cps_mem_pkg::RAM_AW-1:0] dma_addr,
    input  wire logic [cps_mem_pkg::VRAM_BANKS-1:0][15:0] dma_q,
    output logic                       vram_dma_ok,
    output logic [15:0]                vram_dma_data
);

    logic [cps_mem_pkg::RAM_AW-1:0] cap_addr;
    logic [1:0]  cap_bank;
    logic        cap_valid;
    logic        start;
    logic [1:0]  stage;
    logic [15:0] bank_word;

    // Select is a level, so a new access means a new address
    assign start = vram_dma_cs &
                   (!cap_valid || {cap_bank, cap_addr} != vram_dma_addr);

    always_comb begin
        case (cap_bank)
            2'd0:    bank_word = dma_q[0];
            2'd1:    bank_word = dma_q[1];
            2'd2:    bank_word = dma_q[2];
            default: bank_word = cps_mem_pkg::IDLE_DATA;
        endcase
    end

    always_ff @(posedge clk_gfx or posedge rst) begin
        if (rst) begin
            cap_addr      <= '0;
            cap_bank      <= '0;
            cap_valid     <= 1'b0;
            stage         <= '0;
            vram_dma_ok   <= 1'b0;
            vram_dma_data <= cps_mem_pkg::IDLE_DATA;
        end else begin
            stage <= {stage[0], 1'b0};
            if (start) begin
                cap_addr    <= vram_dma_addr[14:0];
                cap_bank    <= vram_dma_addr[16:15];
                cap_valid   <= 1'b1;
                // Restart drops whatever was in flight
                stage       <= 2'b01;
                vram_dma_ok <= 1'b0;
            end else if (stage[1]) begin
                vram_dma_ok   <= 1'b1;
                vram_dma_data <= bank_word;
            end
        end
    end

    assign dma_addr = cap_addr;

    // ok only once the pipeline has drained
    a_ok_idle: assert property (@(posedge clk_gfx) disable iff (rst)
        vram_dma_ok |-> stage == 2'b00);

endmodule

`default_nettype wire

// File: src/cps_mem.sv
//////////////////////////////
// CPS memory block
// Work RAM and three video banks
// behind the CPU and DMA ports
//////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module cps_mem (
    input  wire logic         clk_cpu,
    input  wire logic         clk_gfx,
    input  wire logic         rst,
    // CPU bus
    input  wire logic         main_ram_cs,
    input  wire logic         main_vram_cs,
    input  wire logic         main_rnw,
    input  wire logic [1:0]   dsn,
    input  wire logic [16:0]  main_ram_addr,
    input  wire logic [15:0]  main_dout,
    output logic              main_ram_ok,
    output logic [15:0]       main_ram_data,
    // Graphics DMA
    input  wire logic         vram_dma_cs,
    input  wire logic [16:0]  vram_dma_addr,
    output logic              vram_dma_ok,
    output logic [15:0]       vram_dma_data
);

    cps_mem_pkg::mem_wr_t mem_wr;
    logic [1:0]  wram_we;
    logic [cps_mem_pkg::VRAM_BANKS-1:0][1:0]  vram_we;
    logic [15:0] wram_q;
    logic [cps_mem_pkg::VRAM_BANKS-1:0][15:0] vram_q;
    logic [cps_mem_pkg::RAM_AW-1:0] dma_addr;
    logic [cps_mem_pkg::VRAM_BANKS-1:0][15:0] dma_q;

    cps_cpu_port u_cpu_port (
        .clk_cpu       (clk_cpu),
        .rst           (rst),
        .main_ram_cs   (main_ram_cs),
        .main_vram_cs  (main_vram_cs),
        .main_rnw      (main_rnw),
        .dsn           (dsn),
        .main_ram_addr (main_ram_addr),
        .main_dout     (main_dout),
        .main_ram_ok   (main_ram_ok),
        .main_ram_data (main_ram_data),
        .mem_wr        (mem_wr),
        .wram_we       (wram_we),
        .vram_we       (vram_we),
        .wram_q        (wram_q),
        .vram_q        (vram_q)
    );

    cps_dma_port u_dma_port (
        .clk_gfx       (clk_gfx),
        .rst           (rst),
        .vram_dma_cs   (vram_dma_cs),
        .vram_dma_addr (vram_dma_addr),
        .dma_addr      (dma_addr),
        .dma_q         (dma_q),
        .vram_dma_ok   (vram_dma_ok),
        .vram_dma_data (vram_dma_data)
    );

    // CPU-only work RAM
    cps_word_ram u_wram (
        .clk_cpu (clk_cpu),
        .wr      (mem_wr),
        .we      (wram_we),
        .q       (wram_q)
    );

    for (genvar b = 0; b < cps_mem_pkg::VRAM_BANKS; b++) begin : g_vram
        cps_vram_bank u_bank (
            .clk_cpu  (clk_cpu),
            .clk_gfx  (clk_gfx),
            .wr       (mem_wr),
            .we       (vram_we[b]),
            .q        (vram_q[b]),
            .dma_addr (dma_addr),
            .dma_q    (dma_q[b])
        );
    end

endmodule

`default_nettype wire

// File: verif/cps_mem_checker.sv
//////////////////////////////
// CPS memory checker
// Shadow model of all four
// memories and response checks
// on the CPU and DMA ports
//////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module cps_mem_checker (
    input  wire logic        clk_cpu,
    input  wire logic        clk_gfx,
    input  wire logic        rst,
    input  wire logic        main_ram_cs,
    input  wire logic        main_vram_cs,
    input  wire logic        main_rnw,
    input  wire logic [1:0]  dsn,
    input  wire logic [16:0] main_ram_addr,
    input  wire logic [15:0] main_dout,
    input  wire logic        main_ram_ok,
    input  wire logic [15:0] main_ram_data,
    input  wire logic        vram_dma_cs,
    input  wire logic [16:0] vram_dma_addr,
    input  wire logic        vram_dma_ok,
    input  wire logic [15:0] vram_dma_data,
    output int               errors
);

    // Shadow words, row 0 work RAM, rows 1 to 3 video banks
    logic [15:0] shadow [4][2**cps_mem_pkg::RAM_AW];
    cps_mem_pkg::mem_target_e tgt;
    logic        cpu_sel_last;
    logic        cpu_rnw;
    logic        cpu_fresh;
    logic [15:0] cpu_exp;
    int          cpu_cnt;
    int          cpu_errors = 0;
    logic [16:0] dma_last;
    logic        dma_valid;
    logic        dma_done;
    logic        dma_fresh;
    logic [15:0] dma_exp;
    int          dma_cnt;
    int          dma_errors = 0;

    // Board memory map, bits 16:15 pick the video bank
    function automatic cps_mem_pkg::mem_target_e target_of(input logic ram_sel,
                                                         input logic [16:0] a);
        if (ram_sel) begin
            return cps_mem_pkg::TGT_WRAM;
        end
        case (a[16:15])
            2'd0:    return cps_mem_pkg::TGT_VRAM0;
            2'd1:    return cps_mem_pkg::TGT_VRAM1;
            2'd2:    return cps_mem_pkg::TGT_VRAM2;
            default: return cps_mem_pkg::TGT_NONE;
        endcase
    endfunction

    // Reference model of a read
    function automatic logic [15:0] expected_word(input cps_mem_pkg::mem_target_e t,
                                                  input logic [14:0] a);
        if (t == cps_mem_pkg::TGT_NONE) begin
            return cps_mem_pkg::IDLE_DATA;
        end
        return shadow[t[1:0]][a];
    endfunction

    task automatic apply_write(input cps_mem_pkg::mem_target_e t, input logic [14:0] a,
                               input logic [1:0] be, input logic [15:0] d);
        if (t != cps_mem_pkg::TGT_NONE) begin
            if (be[1]) shadow[t[1:0]][a][15:8] = d[15:8];
            if (be[0]) shadow[t[1:0]][a][7:0] = d[7:0];
        end
    endtask

    function automatic bit word_differs(input string name, input logic [15:0] got,
                                        input logic [15:0] exp);
        if (got !== exp) begin
            $display("error %s: got %h expected %h at %0t", name, got, exp, $time);
        end
        return got !== exp;
    endfunction

    always @(posedge clk_cpu) begin
        if (rst) begin
            cpu_sel_last = 1'b0;
            cpu_cnt = 0;
            cpu_fresh = 1'b1;
        end else begin
            if (cpu_fresh) begin
                if (word_differs("main_ram_ok", {15'd0, main_ram_ok}, 16'd0)) cpu_errors++;
                if (word_differs("main_ram_data", main_ram_data, cps_mem_pkg::IDLE_DATA))
                    cpu_errors++;
                cpu_fresh = 1'b0;
            end
            // ok low through the second edge, high after it
            if (cpu_cnt > 0) begin
                cpu_cnt++;
                if (word_differs("main_ram_ok", {15'd0, main_ram_ok}, {15'd0, cpu_cnt == 4}))
                    cpu_errors++;
                if (cpu_cnt == 4) begin
                    if (cpu_rnw && word_differs("main_ram_data", main_ram_data, cpu_exp))
                        cpu_errors++;
                    cpu_cnt = 0;
                end
            end
            if ((main_ram_cs || main_vram_cs) && !cpu_sel_last) begin
                tgt = target_of(main_ram_cs, main_ram_addr);
                // Read-first memories, so take the word before the write
                cpu_exp = expected_word(tgt, main_ram_addr[14:0]);
                cpu_rnw = main_rnw;
                if (!main_rnw) apply_write(tgt, main_ram_addr[14:0], ~dsn, main_dout);
                cpu_cnt = 1;
            end
            cpu_sel_last = main_ram_cs || main_vram_cs;
        end
    end

    always @(posedge clk_gfx) begin
        if (rst) begin
            dma_valid = 1'b0;
            dma_cnt = 0;
            dma_done = 1'b0;
            dma_fresh = 1'b1;
        end else begin
            if (dma_fresh) begin
                if (word_differs("vram_dma_ok", {15'd0, vram_dma_ok}, 16'd0)) dma_errors++;
                if (word_differs("vram_dma_data", vram_dma_data, cps_mem_pkg::IDLE_DATA))
                    dma_errors++;
                dma_fresh = 1'b0;
            end
            if (dma_cnt > 0) begin
                dma_cnt++;
                if (word_differs("vram_dma_ok", {15'd0, vram_dma_ok}, {15'd0, dma_cnt == 4}))
                    dma_errors++;
                if (dma_cnt == 4) begin
                    if (word_differs("vram_dma_data", vram_dma_data, dma_exp)) dma_errors++;
                    dma_cnt = 0;
                    dma_done = 1'b1;
                end
            end else if (dma_done) begin
                // Result held until the next address change
                if (word_differs("vram_dma_ok", {15'd0, vram_dma_ok}, 16'd1)) dma_errors++;
                if (word_differs("vram_dma_data", vram_dma_data, dma_exp)) dma_errors++;
            end
            if (vram_dma_cs && (!dma_valid || vram_dma_addr != dma_last)) begin
                dma_last = vram_dma_addr;
                dma_valid = 1'b1;
                dma_exp = expected_word(target_of(1'b0, vram_dma_addr), vram_dma_addr[14:0]);
                dma_cnt = 1;
                dma_done = 1'b0;
            end
        end
    end

    assign errors = cpu_errors + dma_errors;

endmodule

`default_nettype wire

// File: verif/cps_mem_tb.sv
//////////////////////////////
// CPS memory testbench
// Random CPU and DMA traffic
// into the memory block
//////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module cps_mem_tb;

    localparam int OK_TIMEOUT = 16;

    logic        clk_cpu;
    logic        clk_gfx;
    logic        rst;
    logic        main_ram_cs;
    logic        main_vram_cs;
    logic        main_rnw;
    logic [1:0]  dsn;
    logic [16:0] main_ram_addr;
    logic [15:0] main_dout;
    logic        main_ram_ok;
    logic [15:0] main_ram_data;
    logic        vram_dma_cs;
    logic [16:0] vram_dma_addr;
    logic        vram_dma_ok;
    logic [15:0] vram_dma_data;
    logic [31:0] rng;
    logic [14:0] addr_tab [8];
    logic [1:0]  strobes;
    int          check_errors;
    int          timeouts;

    cps_mem DUT (.*);

    cps_mem_checker u_check (.*, .errors(check_errors));

    initial begin
        clk_cpu = 1'b0;
        forever #50 clk_cpu = ~clk_cpu;
    end

    initial begin
        clk_gfx = 1'b0;
        forever #25 clk_gfx = ~clk_gfx;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Target 0 is work RAM, 1 to 4 are video banks 0 to 3
    function automatic logic [16:0] bus_addr(input int t, input logic [14:0] a,
                                             input logic [1:0] spare);
        if (t == 0) begin
            return {spare, a};
        end
        return {2'(t - 1), a};
    endfunction

    task automatic cpu_access(input int t, input logic rnw, input logic [1:0] be_n,
                              input logic [14:0] a, input logic [15:0] data);
        int n;
        @(posedge clk_cpu);
        #5;
        rng = xorshift32(rng);
        main_ram_cs = (t == 0);
        main_vram_cs = (t != 0);
        main_rnw = rnw;
        dsn = be_n;
        main_ram_addr = bus_addr(t, a, rng[1:0]);
        main_dout = data;
        n = 0;
        do begin
            @(posedge clk_cpu);
            #5;
            n++;
        end while (!main_ram_ok && n < OK_TIMEOUT);
        if (!main_ram_ok) begin
            $display("timeout: main_ram_ok never rose for address %h", main_ram_addr);
            timeouts++;
        end
        main_ram_cs = 1'b0;
        main_vram_cs = 1'b0;
    endtask

    task automatic wait_dma_ok();
        int n;
        n = 0;
        do begin
            @(posedge clk_gfx);
            #5;
            n++;
        end while (!vram_dma_ok && n < OK_TIMEOUT);
        if (!vram_dma_ok) begin
            $display("timeout: vram_dma_ok never rose for address %h", vram_dma_addr);
            timeouts++;
        end
        // Select stays up, result must hold
        repeat (3) @(posedge clk_gfx);
    endtask

    // New address on each of len back-to-back gfx cycles
    task automatic dma_burst(input int len);
        for (int k = 0; k < len; k++) begin
            @(posedge clk_gfx);
            #5;
            rng = xorshift32(rng);
            vram_dma_cs = 1'b1;
            vram_dma_addr = bus_addr(1 + k % 3, addr_tab[rng[2:0]], 2'b00);
        end
        wait_dma_ok();
    endtask

    initial begin
        rst = 1'b1;
        main_ram_cs = 1'b0;
        main_vram_cs = 1'b0;
        main_rnw = 1'b1;
        dsn = 2'b11;
        main_ram_addr = '0;
        main_dout = '0;
        vram_dma_cs = 1'b0;
        vram_dma_addr = '0;
        timeouts = 0;
        rng = 32'h6416c893;
        for (int i = 0; i < 8; i++) begin
            rng = xorshift32(rng);
            addr_tab[i] = rng[14:0];
        end
        repeat (10) @(posedge clk_cpu);
        #5;
        rst = 1'b0;

        // Full words everywhere, bank 3 included
        for (int t = 0; t < 5; t++) begin
            for (int i = 0; i < 8; i++) begin
                rng = xorshift32(rng);
                cpu_access(t, 1'b0, 2'b00, addr_tab[i], rng[31:16]);
            end
        end
        // High byte, low byte or both
        for (int k = 0; k < 16; k++) begin
            rng = xorshift32(rng);
            strobes = (rng[1:0] == 2'd3) ? 2'b00 : rng[1:0];
            cpu_access(int'(rng[4:2]) % 5, 1'b0, strobes, addr_tab[rng[7:5]], rng[31:16]);
        end
        for (int t = 0; t < 5; t++) begin
            for (int i = 0; i < 8; i++) begin
                cpu_access(t, 1'b1, 2'b00, addr_tab[i], 16'h0000);
            end
        end

        // Quiet gap before the graphics side reads
        repeat (20) @(posedge clk_cpu);
        for (int k = 0; k < 24; k++) begin
            @(posedge clk_gfx);
            #5;
            rng = xorshift32(rng);
            vram_dma_cs = 1'b1;
            vram_dma_addr = bus_addr(1 + int'(rng[1:0]), addr_tab[rng[4:2]], 2'b00);
            wait_dma_ok();
        end
        dma_burst(3);
        dma_burst(4);
        @(posedge clk_gfx);
        #5;
        vram_dma_cs = 1'b0;
        repeat (4) @(posedge clk_gfx);

        $display("check errors %0d, timeouts %0d", check_errors, timeouts);
        if (check_errors == 0 && timeouts == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: cps_mem.f
src/cps_mem_pkg.sv
src/cps_word_ram.sv
src/cps_vram_bank.sv
src/cps_cpu_port.sv
src/cps_dma_port.sv
src/cps_mem.sv
verif/cps_mem_checker.sv
verif/cps_mem_tb.sv

// File: Makefile
# Verilator build and run of the CPS memory testbench

TOP := cps_mem_tb

.PHONY: all compile run clean

all: run

compile: obj_dir/V$(TOP)

obj_dir/V$(TOP): cps_mem.f src/*.sv verif/*.sv
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f cps_mem.f -Mdir obj_dir

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "ERRORS FOUND" sim.log || ! grep -q "NO ERRORS" sim.log; then \
		echo "simulation failed"; \
		exit 1; \
	else \
		echo "simulation passed"; \
	fi

clean:
	rm -rf obj_dir sim.log
